// ==== dv/fetch_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_properties (
    input wire clk,
    input wire rst,
    input wire i_enable0,
    input wire i_stall0,
    input wire i_enable1,
    input wire i_stall1,
    input wire i_req0,
    input wire i_ack0,
    input wire i_req1,
    input wire i_ack1,
    input wire i_rsp,
    input wire i_in_use,
    input wire i_rd_req,
    input wire i_rd_valid,
    input wire i_rd_ack
);

    int fail_count = 0;  // read by the testbench

    // a cache keeps req up until it has taken its line
    req0_held: assert property (@(posedge clk) disable iff (rst)
        i_req0 && !i_ack0 |=> i_req0 || i_ack0)
        else begin
            fail_count = fail_count + 1;
            $error("req0 dropped before ack");
        end

    req1_held: assert property (@(posedge clk) disable iff (rst)
        i_req1 && !i_ack1 |=> i_req1 || i_ack1)
        else begin
            fail_count = fail_count + 1;
            $error("req1 dropped before ack");
        end

    rsp_held: assert property (@(posedge clk) disable iff (rst)
        i_rsp && !(i_ack0 || i_ack1) |=> i_rsp)
        else begin
            fail_count = fail_count + 1;
            $error("rsp dropped before ack");
        end

    // any open phase of either handshake keeps the arbiter busy
    busy_open: assert property (@(posedge clk) disable iff (rst)
        (i_rd_req || i_rd_valid || i_rd_ack || i_rsp) |-> i_in_use)
        else begin
            fail_count = fail_count + 1;
            $error("in_use low with a transaction open");
        end

    no_stall_idle0: assert property (@(posedge clk)
        !i_enable0 |-> !i_stall0)
        else begin
            fail_count = fail_count + 1;
            $error("stall0 high without enable");
        end

    no_stall_idle1: assert property (@(posedge clk)
        !i_enable1 |-> !i_stall1)
        else begin
            fail_count = fail_count + 1;
            $error("stall1 high without enable");
        end

    reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !(i_req0 || i_req1 || i_ack0 || i_ack1 || i_rsp
                         || i_in_use || i_rd_req || i_rd_ack))
        else begin
            fail_count = fail_count + 1;
            $error("handshake signal high after reset");
        end

endmodule

bind fetch_top fetch_properties props_inst (
    .clk(clk), .rst(rst),
    .i_enable0(i_enable0), .i_stall0(o_stall0),
    .i_enable1(i_enable1), .i_stall1(o_stall1),
    .i_req0(mem0_if.req), .i_ack0(mem0_if.ack),
    .i_req1(mem1_if.req), .i_ack1(mem1_if.ack),
    .i_rsp(mem0_if.rsp), .i_in_use(mem0_if.in_use),
    .i_rd_req(rd_req), .i_rd_valid(rd_valid), .i_rd_ack(rd_ack)
);

`default_nettype wire

// ==== dv/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int N_SETS       = 4;
    localparam int N_WAYS       = 2;
    localparam int MEM_LATENCY  = 4;
    localparam int N_RANDOM     = 200;
    localparam int N_FETCHES    = N_RANDOM + 20;  // all fetches of all tests rounded up
    localparam int FETCH_CYCLES = MEM_LATENCY + 20;
    localparam int MUST_HIT     = 0;
    localparam int MUST_MISS    = 1;
    localparam int EITHER       = 2;

    logic  clk = 1'b0;
    logic  rst;
    logic  enable0;
    addr_t addr0;
    logic  stall0;
    word_t word0;
    logic  enable1;
    addr_t addr1;
    logic  stall1;
    word_t word1;

    fetch_top #(.N_SETS(N_SETS), .N_WAYS(N_WAYS), .MEM_LATENCY(MEM_LATENCY)) fetch_top_inst (
        .clk(clk), .rst(rst),
        .i_enable0(enable0), .i_addr0(addr0), .o_stall0(stall0), .o_word0(word0),
        .i_enable1(enable1), .i_addr1(addr1), .o_stall1(stall1), .o_word1(word1)
    );

    always #10 clk = ~clk;

    // word address in the low half, its inverse in the high half
    function automatic word_t predict_word(input addr_t byte_addr);
        logic [15:0] word_addr;
        word_addr = byte_addr >> 2;
        return {~word_addr, word_addr};
    endfunction

    task automatic check_word(input string test, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %h, actual %h", test, expected, actual);
            $display("Test FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_stall(input string test, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("ERR %s: stall expected %b, actual %b", test, expected, actual);
            $display("Test FAILED");
            $fatal(1, "stall mismatch");
        end
    endtask

    // one fetch on one port, held until the stall ends
    task automatic fetch(input string test, input int port, input addr_t addr, input int mode);
        logic  stall;
        word_t word;
        int    waited;
        @(negedge clk);
        if (port == 0) begin
            enable0 = 1'b1;
            addr0   = addr;
        end else begin
            enable1 = 1'b1;
            addr1   = addr;
        end
        @(posedge clk);
        stall = (port == 0) ? stall0 : stall1;
        if (mode != EITHER) begin
            check_stall(test, (mode == MUST_MISS), stall);
        end
        waited = 0;
        while (stall) begin
            if (waited > 2 * FETCH_CYCLES) begin
                $display("%s: port %0d stayed stalled on address %h", test, port, addr);
                $display("Test FAILED");
                $fatal(1, "fetch never completed");
            end
            @(posedge clk);
            waited++;
            stall = (port == 0) ? stall0 : stall1;
        end
        word = (port == 0) ? word0 : word1;
        check_word(test, predict_word(addr), word);
        @(negedge clk);
        if (port == 0) begin
            enable0 = 1'b0;
        end else begin
            enable1 = 1'b0;
        end
    endtask

    task automatic reset_state();
        @(posedge clk);
        check_stall("reset", 1'b0, stall0);
        check_stall("reset", 1'b0, stall1);
        fetch("reset", 1, 16'h0200, MUST_MISS);  // valid bits must be clear
    endtask

    task automatic cold_miss();
        fetch("cold_miss", 0, 16'h0040, MUST_MISS);
    endtask

    task automatic hit_all_words();
        for (int w = 0; w < 4; w++) begin
            fetch("hit", 0, addr_t'(16'h0040 + w * 4), MUST_HIT);
        end
    endtask

    task automatic port_contention();
        fork
            fetch("contention", 0, 16'h0080, MUST_MISS);
            fetch("contention", 1, 16'h00c4, MUST_MISS);
        join
    endtask

    // four lines of set 0 against two ways
    task automatic set_replacement();
        for (int l = 0; l < 4; l++) begin
            fetch("replacement", 0, addr_t'(16'h0300 + l * 16'h0040), MUST_MISS);
        end
        for (int l = 0; l < 4; l++) begin
            fetch("replacement", 0, addr_t'(16'h0300 + l * 16'h0040 + 4 * l), EITHER);
        end
    endtask

    task automatic random_stream();
        addr_t addr;
        for (int i = 0; i < N_RANDOM; i++) begin
            addr = addr_t'(($urandom % 128) * 4);  // 512 byte region
            fetch("random", i % 2, addr, EITHER);
        end
    endtask

    initial begin
        repeat (8 + N_FETCHES * FETCH_CYCLES) @(posedge clk);
        $display("watchdog expired, the DUT stopped completing fetches");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        wait (fetch_top_inst.props_inst.fail_count != 0);
        $display("a bound handshake assertion failed");
        $display("Test FAILED");
        $fatal(1, "assertion failure");
    end

    initial begin
        void'($urandom(32'h7cdf_c742));
        rst     = 1'b1;
        enable0 = 1'b0;
        addr0   = '0;
        enable1 = 1'b0;
        addr1   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_state();
        cold_miss();
        hit_all_words();
        port_contention();
        set_replacement();
        random_stream();

        @(negedge clk);
        if (fetch_top_inst.props_inst.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("bound assertions reported failures");
            $display("Test FAILED");
            $fatal(1, "assertion failure");
        end
    end

endmodule

`default_nettype wire

// ==== src/cache_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cache_mem_if;
    import fetch_pkg::*;

    logic    req;       // line request, held until the response is taken
    addr_t   addr;      // line address, word bits zero
    logic    ack;       // response taken
    mem_id_t next_id;   // id owned on grant
    logic    in_use;    // memory side busy
    logic    rsp;       // broadcast response
    mem_id_t rsp_id;
    line_t   rsp_line;

    modport cache (
        output req, addr, ack,
        input  next_id, in_use, rsp, rsp_id, rsp_line
    );

    modport arbiter (
        input  req, addr, ack,
        output next_id, in_use, rsp, rsp_id, rsp_line
    );

endinterface

`default_nettype wire

// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int ADDR_WIDTH = 16;  // byte fetch address
    localparam int WORD_BYTES = 4;
    localparam int LINE_WORDS = 4;
    localparam int ID_WIDTH   = 3;   // memory transaction id

    localparam int WORD_WIDTH     = WORD_BYTES * 8;
    localparam int LINE_WIDTH     = LINE_WORDS * WORD_WIDTH;
    localparam int BYTE_SEL_WIDTH = $clog2(WORD_BYTES);
    localparam int WORD_SEL_WIDTH = $clog2(LINE_WORDS);
    // byte offset inside one line
    localparam int OFFSET_WIDTH   = BYTE_SEL_WIDTH + WORD_SEL_WIDTH;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [LINE_WIDTH-1:0] line_t;  // word 0 in the low bits
    typedef logic [ID_WIDTH-1:0]   mem_id_t;

    typedef enum logic {
        IDLE,     // ready to look up
        REQUEST   // line fill outstanding
    } cache_state_t;

    // instruction image: word address low, its inverse high
    function automatic word_t mem_word(input addr_t word_addr);
        logic [WORD_WIDTH/2-1:0] low;
        low = word_addr;
        return {~low, low};
    endfunction

endpackage

`default_nettype wire

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int N_SETS      = 4,
    parameter int N_WAYS      = 2,
    parameter int MEM_LATENCY = 4
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_enable0,
    input  wire fetch_pkg::addr_t i_addr0,
    output logic                  o_stall0,
    output fetch_pkg::word_t      o_word0,
    input  wire                   i_enable1,
    input  wire fetch_pkg::addr_t i_addr1,
    output logic                  o_stall1,
    output fetch_pkg::word_t      o_word1
);
    import fetch_pkg::*;

    localparam int WAY_BITS = (N_WAYS > 1) ? $clog2(N_WAYS) : 1;

    logic [WAY_BITS-1:0] victim0;
    logic [WAY_BITS-1:0] victim1;
    logic                miss0;
    logic                miss1;
    logic                rd_req;
    addr_t               rd_addr;
    logic                rd_ack;
    logic                rd_valid;
    line_t               rd_line;

    cache_mem_if mem0_if ();
    cache_mem_if mem1_if ();

    // separate seeds so the two ports pick victims independently
    replace_lfsr #(.WIDTH(WAY_BITS), .LFSR_SEED(8'h5a)) lfsr0_inst (
        .clk(clk), .rst(rst), .i_step(miss0), .o_way(victim0)
    );

    replace_lfsr #(.WIDTH(WAY_BITS), .LFSR_SEED(8'hc3)) lfsr1_inst (
        .clk(clk), .rst(rst), .i_step(miss1), .o_way(victim1)
    );

    icache #(.N_SETS(N_SETS), .N_WAYS(N_WAYS)) icache0_inst (
        .clk(clk), .rst(rst), .i_enable(i_enable0), .i_addr(i_addr0), .i_victim(victim0),
        .o_stall(o_stall0), .o_word(o_word0), .mem(mem0_if), .o_miss(miss0)
    );

    icache #(.N_SETS(N_SETS), .N_WAYS(N_WAYS)) icache1_inst (
        .clk(clk), .rst(rst), .i_enable(i_enable1), .i_addr(i_addr1), .i_victim(victim1),
        .o_stall(o_stall1), .o_word(o_word1), .mem(mem1_if), .o_miss(miss1)
    );

    mem_arbiter arbiter_inst (
        .clk(clk), .rst(rst), .port0(mem0_if), .port1(mem1_if),
        .o_rd_req(rd_req), .o_rd_addr(rd_addr), .o_rd_ack(rd_ack),
        .i_rd_valid(rd_valid), .i_rd_line(rd_line)
    );

    line_memory #(.MEM_LATENCY(MEM_LATENCY)) line_memory_inst (
        .clk(clk), .rst(rst), .i_rd_req(rd_req), .i_rd_addr(rd_addr),
        .o_rd_valid(rd_valid), .o_rd_line(rd_line), .i_rd_ack(rd_ack)
    );

endmodule

`default_nettype wire

// ==== src/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int  N_SETS   = 4,
    parameter int  N_WAYS   = 2,
    localparam int WAY_BITS = (N_WAYS > 1) ? $clog2(N_WAYS) : 1
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_enable,
    input  wire fetch_pkg::addr_t i_addr,
    input  wire [WAY_BITS-1:0]    i_victim,
    output logic                  o_stall,
    output fetch_pkg::word_t      o_word,
    cache_mem_if.cache            mem,
    output logic                  o_miss
);
    import fetch_pkg::*;

    localparam int SET_BITS = $clog2(N_SETS);
    localparam int TAG_BITS = ADDR_WIDTH - SET_BITS - OFFSET_WIDTH;

    line_t               data_mem [N_SETS][N_WAYS];
    logic [TAG_BITS-1:0] tag_mem  [N_SETS][N_WAYS];
    logic [N_WAYS-1:0]   valid    [N_SETS];

    cache_state_t        state;
    mem_id_t             id_q;          // id owned by the outstanding fill
    logic [WAY_BITS-1:0] victim_q;
    addr_t               line_addr_q;
    logic                ack_q;

    logic [TAG_BITS-1:0]       addr_tag;
    logic [SET_BITS-1:0]       addr_set;
    logic [WORD_SEL_WIDTH-1:0] addr_word;
    addr_t                     req_addr;
    logic [TAG_BITS-1:0]       fill_tag;
    logic [SET_BITS-1:0]       fill_set;
    logic                      hit;
    logic [WAY_BITS-1:0]       hit_way;
    line_t                     hit_line;
    logic                      start;
    logic                      take;

    assign addr_tag  = i_addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign addr_set  = i_addr[OFFSET_WIDTH +: SET_BITS];
    assign addr_word = i_addr[BYTE_SEL_WIDTH +: WORD_SEL_WIDTH];
    assign req_addr  = {i_addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    assign fill_tag  = line_addr_q[ADDR_WIDTH-1 -: TAG_BITS];
    assign fill_set  = line_addr_q[OFFSET_WIDTH +: SET_BITS];

    // all ways of the set compared at once
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (valid[addr_set][w] && (tag_mem[addr_set][w] == addr_tag)) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit_line = data_mem[addr_set][hit_way];
    assign o_word   = hit_line[addr_word*WORD_WIDTH +: WORD_WIDTH];
    assign o_stall  = i_enable && !hit;
    assign o_miss   = o_stall;  // steps the victim LFSR

    // new request only when nobody else holds the memory
    assign start = (state == IDLE) && i_enable && !hit && !mem.in_use;
    assign take  = (state == REQUEST) && mem.rsp && (mem.rsp_id == id_q);

    assign mem.req  = start || (state == REQUEST);
    assign mem.addr = (state == IDLE) ? req_addr : line_addr_q;
    assign mem.ack  = ack_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            ack_q <= 1'b0;
            for (int s = 0; s < N_SETS; s++) begin
                valid[s] <= '0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (take) begin
                        state                     <= IDLE;
                        valid[fill_set][victim_q] <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase

            // ack held until the arbiter drops rsp
            if (take) begin
                ack_q <= 1'b1;
            end else if (!mem.rsp) begin
                ack_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            id_q        <= mem.next_id;
            victim_q    <= i_victim;
            line_addr_q <= req_addr;
        end
        if (take) begin
            data_mem[fill_set][victim_q] <= mem.rsp_line;
            tag_mem[fill_set][victim_q]  <= fill_tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/line_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_memory #(
    parameter int MEM_LATENCY = 4   // at least 1
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   i_rd_req,
    input  wire fetch_pkg::addr_t i_rd_addr,
    output logic                  o_rd_valid,
    output fetch_pkg::line_t      o_rd_line,
    input  wire                   i_rd_ack
);
    import fetch_pkg::*;

    localparam int LINE_ADDR_BITS = ADDR_WIDTH - OFFSET_WIDTH;
    localparam int N_LINES        = 2 ** LINE_ADDR_BITS;
    localparam int CNT_BITS       = $clog2(MEM_LATENCY + 1);

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT,    // counting latency
        MEM_VALID,   // line presented, waiting for ack
        MEM_DONE     // waiting for req and ack low
    } mem_state_t;

    line_t                     rom [N_LINES];
    mem_state_t                state;
    logic [CNT_BITS-1:0]       lat_cnt;
    logic [LINE_ADDR_BITS-1:0] line_idx;

    // whole image built once from the content rule
    initial begin
        for (int l = 0; l < N_LINES; l++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                rom[l][w*WORD_WIDTH +: WORD_WIDTH] = mem_word(addr_t'(l * LINE_WORDS + w));
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= MEM_IDLE;
            lat_cnt    <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (i_rd_req) begin
                        lat_cnt <= CNT_BITS'(MEM_LATENCY - 1);
                        state   <= MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    if (lat_cnt == '0) begin
                        o_rd_valid <= 1'b1;
                        state      <= MEM_VALID;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                MEM_VALID: begin
                    if (i_rd_ack) begin
                        o_rd_valid <= 1'b0;
                        state      <= MEM_DONE;
                    end
                end
                MEM_DONE: begin
                    if (!i_rd_req && !i_rd_ack) begin
                        state <= MEM_IDLE;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == MEM_IDLE) && i_rd_req) begin
            line_idx <= i_rd_addr[ADDR_WIDTH-1:OFFSET_WIDTH];
        end
        if ((state == MEM_WAIT) && (lat_cnt == '0)) begin
            o_rd_line <= rom[line_idx];
        end
    end

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                   clk,
    input  wire                   rst,
    cache_mem_if.arbiter          port0,
    cache_mem_if.arbiter          port1,
    output logic                  o_rd_req,
    output fetch_pkg::addr_t      o_rd_addr,
    output logic                  o_rd_ack,
    input  wire                   i_rd_valid,
    input  wire fetch_pkg::line_t i_rd_line
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_MEM,    // waiting on line memory
        ARB_RSP,    // response broadcast, waiting for cache ack
        ARB_CLOSE   // both handshakes returning to zero
    } arb_state_t;

    arb_state_t state;
    mem_id_t    id_cnt;
    mem_id_t    cur_id;
    logic       gnt1;       // port 1 owns the transaction
    logic       rsp_q;
    line_t      line_q;
    logic       busy;
    logic       cache_ack;

    assign busy      = (state != ARB_IDLE);
    assign cache_ack = gnt1 ? port1.ack : port0.ack;

    assign port0.next_id = id_cnt;
    assign port1.next_id = id_cnt;
    assign port0.in_use  = busy;
    assign port1.in_use  = busy || port0.req;  // port 0 wins a tie

    assign port0.rsp      = rsp_q;
    assign port1.rsp      = rsp_q;
    assign port0.rsp_id   = cur_id;
    assign port1.rsp_id   = cur_id;
    assign port0.rsp_line = line_q;
    assign port1.rsp_line = line_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ARB_IDLE;
            id_cnt   <= '0;
            cur_id   <= '0;
            gnt1     <= 1'b0;
            rsp_q    <= 1'b0;
            o_rd_req <= 1'b0;
            o_rd_ack <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (port0.req || port1.req) begin
                        gnt1     <= !port0.req;
                        cur_id   <= id_cnt;
                        id_cnt   <= id_cnt + 1'b1;
                        o_rd_req <= 1'b1;
                        state    <= ARB_MEM;
                    end
                end
                ARB_MEM: begin
                    if (i_rd_valid) begin
                        rsp_q    <= 1'b1;
                        o_rd_req <= 1'b0;
                        o_rd_ack <= 1'b1;   // line captured below
                        state    <= ARB_RSP;
                    end
                end
                ARB_RSP: begin
                    if (cache_ack) begin
                        rsp_q <= 1'b0;
                        state <= ARB_CLOSE;
                    end
                end
                ARB_CLOSE: begin
                    if (!cache_ack && !i_rd_valid) begin
                        o_rd_ack <= 1'b0;
                        state    <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            o_rd_addr <= port0.req ? port0.addr : port1.addr;
        end
        if ((state == ARB_MEM) && i_rd_valid) begin
            line_q <= i_rd_line;
        end
    end

endmodule

`default_nettype wire

// ==== src/replace_lfsr.sv ====
`timescale 1ns/1ps
`default_nettype none

module replace_lfsr #(
    parameter int         WIDTH     = 1,
    parameter logic [7:0] LFSR_SEED = 8'h5a   // must be nonzero
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              i_step,
    output logic [WIDTH-1:0] o_way
);

    logic [7:0] lfsr;
    logic       feedback;

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    assign o_way    = lfsr[WIDTH-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else if (i_step) begin
            lfsr <= {lfsr[6:0], feedback};
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
src/fetch_pkg.sv
src/cache_mem_if.sv
src/replace_lfsr.sv
src/icache.sv
src/mem_arbiter.sv
src/line_memory.sv
src/fetch_top.sv
dv/fetch_properties.sv
dv/fetch_tb.sv
